/* core_pkg.sv */
/*
 * core package
 * shared widths, bridge setting addresses, colour-correction gains
 * and the two views of the outgoing video word
 */
package core_pkg;

  localparam int chan_w   = 8;
  localparam int rgb_w    = 24;
  localparam int bridge_w = 32;
  localparam int rtc_w    = 65;

  ////////////////////////////////////////
  // bridge addresses of the kept settings

  localparam logic [bridge_w-1:0] addr_reset_pulse   = 32'h0000_0050;
  localparam logic [bridge_w-1:0] addr_deadzone      = 32'h0000_010C;
  localparam logic [bridge_w-1:0] addr_square_pixels = 32'h0000_0200;
  localparam logic [bridge_w-1:0] addr_color_corr    = 32'h0000_0208;

  // neutral stick position
  localparam logic [chan_w-1:0] stick_center = 8'd128;

  ////////////////////////////////////////
  // colour correction, gains in 1/256

  localparam logic [chan_w-1:0] percent_full = 8'd100;
  localparam logic [9:0] gain_r = 10'd234;
  localparam logic [9:0] gain_g = 10'd258;
  localparam logic [9:0] gain_b = 10'd304;

  typedef struct packed {
    logic [chan_w-1:0] r;
    logic [chan_w-1:0] g;
    logic [chan_w-1:0] b;
  } pixel_view_t;

  // sent once per line after the last active pixel
  typedef struct packed {
    logic [8:0]  pad_hi;
    logic        slot_interlace_odd;
    logic        slot_square;
    logic [12:0] pad_lo;
  } slot_view_t;

  typedef union packed {
    pixel_view_t pixel;
    slot_view_t  slot;
  } video_word_u;

endpackage

/* core_settings_regs.sv */
/*
 * core settings registers
 * decodes bridge writes into the settings kept on the bridge clock
 * and times the core reset pulse started by a bridge write
 */
module core_settings_regs #(
  parameter int reset_pulse_cycles = 1048576
) (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic                          bridge_wr,
  input  logic [core_pkg::bridge_w-1:0] bridge_addr,
  input  logic [core_pkg::bridge_w-1:0] bridge_wr_data,
  output logic                          core_reset,
  output logic [core_pkg::chan_w-1:0]   deadzone,
  output logic [core_pkg::chan_w-1:0]   color_corr,
  output logic                          square_pixels
);

  // wide enough to hold the full pulse length
  localparam int cnt_w = $clog2(reset_pulse_cycles + 1);

  logic [cnt_w-1:0] pulse_count;

  ////////////////////////////////////////
  // reset pulse counter

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pulse_count <= '0;
    end else begin
      if (pulse_count != '0) begin
        pulse_count <= pulse_count - cnt_w'(1);
      end
      // a new write restarts the pulse
      if (bridge_wr && bridge_addr == core_pkg::addr_reset_pulse) begin
        pulse_count <= cnt_w'(reset_pulse_cycles);
      end
    end
  end

  // held while the pll is unlocked too
  assign core_reset = !pll_core_locked || (pulse_count != '0);

  ////////////////////////////////////////
  // settings written from the bridge

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      deadzone      <= '0;
      color_corr    <= '0;
      square_pixels <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        core_pkg::addr_deadzone: begin
          deadzone <= bridge_wr_data[core_pkg::chan_w-1:0];
        end
        core_pkg::addr_color_corr: begin
          color_corr <= bridge_wr_data[core_pkg::chan_w-1:0];
        end
        core_pkg::addr_square_pixels: begin
          square_pixels <= bridge_wr_data[0];
        end
        default: begin
          // other addresses belong to blocks outside this one
        end
      endcase
    end
  end

endmodule

/* stick_deadzone.sv */
/*
 * stick deadzone
 * centres the left stick while its distance from neutral
 * stays within the configured deadzone
 */
module stick_deadzone (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  input  logic [core_pkg::chan_w-1:0] joy_x,
  input  logic [core_pkg::chan_w-1:0] joy_y,
  input  logic [core_pkg::chan_w-1:0] deadzone,
  output logic [core_pkg::chan_w-1:0] stick_x,
  output logic [core_pkg::chan_w-1:0] stick_y
);

  logic [core_pkg::chan_w-1:0] dist_x;
  logic [core_pkg::chan_w-1:0] dist_y;
  logic [core_pkg::chan_w:0]   dist_total;
  logic                        outside;

  // distance of one axis from centre, 0..128
  function automatic logic [core_pkg::chan_w-1:0] axis_dist(
    input logic [core_pkg::chan_w-1:0] axis
  );
    if (axis[7]) begin
      return {1'b0, axis[6:0]};
    end
    return 8'd128 - {1'b0, axis[6:0]};
  endfunction

  assign dist_x     = axis_dist(joy_x);
  assign dist_y     = axis_dist(joy_y);
  assign dist_total = {1'b0, dist_x} + {1'b0, dist_y};
  assign outside    = dist_total > {1'b0, deadzone};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      stick_x <= core_pkg::stick_center;
      stick_y <= core_pkg::stick_center;
    end else begin
      stick_x <= outside ? joy_x : core_pkg::stick_center;
      stick_y <= outside ? joy_y : core_pkg::stick_center;
    end
  end

endmodule

/* color_correct.sv */
/*
 * colour correction output stage
 * blends each channel toward its target gain by the correction
 * strength and sends the video slot word at the end of every line
 */
module color_correct (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  input  logic [core_pkg::rgb_w-1:0]  rgb_in,
  input  logic                        de_in,
  input  logic                        vs_in,
  input  logic [core_pkg::chan_w-1:0] snap_index,
  input  logic [core_pkg::chan_w-1:0] color_corr,
  input  logic                        square_pixels,
  output core_pkg::video_word_u       video_rgb,
  output logic                        video_de
);

  logic [15:0]                 cc_wide;
  logic [core_pkg::chan_w-1:0] cc;
  logic                        prev_de;
  logic                        prev_vs;
  logic [core_pkg::chan_w-1:0] latched_snap;
  core_pkg::video_word_u       pix_word;
  core_pkg::video_word_u       slot_word;

  // one channel, saturated at 255
  function automatic logic [7:0] blend(
    input logic [7:0] c,
    input logic [9:0] gain,
    input logic [7:0] strength
  );
    logic [15:0] keep_term;
    logic [9:0]  scaled;
    logic [17:0] gain_term;
    logic [18:0] sum;
    logic [10:0] result;
    keep_term = 16'(c) * (16'd255 - 16'(strength));
    scaled    = 10'((18'(c) * 18'(gain)) >> 8);
    gain_term = 18'(scaled) * 18'(strength);
    sum       = 19'(keep_term) + 19'(gain_term);
    result    = sum[18:8];
    return (result > 11'd255) ? 8'd255 : result[7:0];
  endfunction

  ////////////////////////////////////////
  // correction strength, 0..100 to 0..255

  assign cc_wide = (16'(color_corr) * 16'd255) / 16'(core_pkg::percent_full);
  assign cc      = (cc_wide > 16'd255) ? 8'd255 : cc_wide[7:0];

  always_comb begin
    pix_word.pixel.r = blend(rgb_in[23:16], core_pkg::gain_r, cc);
    pix_word.pixel.g = blend(rgb_in[15:8], core_pkg::gain_g, cc);
    pix_word.pixel.b = blend(rgb_in[7:0], core_pkg::gain_b, cc);
  end

  always_comb begin
    slot_word.slot.pad_hi             = '0;
    slot_word.slot.slot_interlace_odd = ~latched_snap[0];
    slot_word.slot.slot_square        = square_pixels;
    slot_word.slot.pad_lo             = '0;
  end

  ////////////////////////////////////////
  // output register

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_de      <= 1'b0;
      prev_vs      <= 1'b0;
      latched_snap <= '0;
      video_de     <= 1'b0;
      video_rgb    <= '0;
    end else begin
      prev_de  <= de_in;
      prev_vs  <= vs_in;
      video_de <= de_in;
      // snap index only settles at vsync
      if (vs_in && !prev_vs) begin
        latched_snap <= snap_index;
      end
      if (de_in) begin
        video_rgb <= pix_word;
      end else if (prev_de) begin
        // end of line, send the slot word
        video_rgb <= slot_word;
      end
    end
  end

endmodule

/* rtc_packer.sv */
/*
 * rtc word packer
 * toggles a change flag on every new bridge time and packs
 * date and time into the console rtc layout
 */
module rtc_packer (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic [core_pkg::bridge_w-1:0] rtc_date,
  input  logic [core_pkg::bridge_w-1:0] rtc_time,
  output logic [core_pkg::rtc_w-1:0]    rtc_word
);

  logic [core_pkg::bridge_w-1:0] prev_time;
  logic                          rtc_changed;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time   <= '0;
      rtc_changed <= 1'b0;
    end else if (rtc_time != prev_time) begin
      prev_time   <= rtc_time;
      rtc_changed <= ~rtc_changed;
    end
  end

  // weekday is not reported by the bridge, fixed at 1
  assign rtc_word = {
    rtc_changed,
    8'h00,
    8'h01,
    rtc_date[23:16],
    rtc_date[15:8],
    rtc_date[7:0],
    rtc_time[23:16],
    rtc_time[15:8],
    rtc_time[7:0]
  };

endmodule

/* core_top.sv */
/*
 * core top level, bridge clock part
 * settings registers beside the stick, video and rtc datapaths
 */
module core_top #(
  parameter int reset_pulse_cycles = 1048576
) (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic [core_pkg::bridge_w-1:0] bridge_addr,
  input  logic                          bridge_wr,
  input  logic [core_pkg::bridge_w-1:0] bridge_wr_data,
  input  logic [31:0]                   cont1_joy,
  input  logic [core_pkg::bridge_w-1:0] rtc_date,
  input  logic [core_pkg::bridge_w-1:0] rtc_time,
  input  logic [core_pkg::rgb_w-1:0]    rgb_in,
  input  logic                          de_in,
  input  logic                          vs_in,
  input  logic [core_pkg::chan_w-1:0]   snap_index,
  output logic                          core_reset,
  output logic [core_pkg::chan_w-1:0]   stick_x,
  output logic [core_pkg::chan_w-1:0]   stick_y,
  output logic [23:0]                   video_rgb,
  output logic                          video_de,
  output logic [core_pkg::rtc_w-1:0]    rtc_word
);

  logic [core_pkg::chan_w-1:0] deadzone;
  logic [core_pkg::chan_w-1:0] color_corr;
  logic                        square_pixels;

  ////////////////////////////////////////
  // settings

  core_settings_regs #(
    .reset_pulse_cycles(reset_pulse_cycles)
  ) i_settings (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .core_reset     (core_reset),
    .deadzone       (deadzone),
    .color_corr     (color_corr),
    .square_pixels  (square_pixels)
  );

  ////////////////////////////////////////
  // datapaths

  // left stick x in byte 0, y in byte 1
  stick_deadzone i_stick (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .joy_x          (cont1_joy[7:0]),
    .joy_y          (cont1_joy[15:8]),
    .deadzone       (deadzone),
    .stick_x        (stick_x),
    .stick_y        (stick_y)
  );

  color_correct i_color (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rgb_in         (rgb_in),
    .de_in          (de_in),
    .vs_in          (vs_in),
    .snap_index     (snap_index),
    .color_corr     (color_corr),
    .square_pixels  (square_pixels),
    .video_rgb      (video_rgb),
    .video_de       (video_de)
  );

  rtc_packer i_rtc (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rtc_date       (rtc_date),
    .rtc_time       (rtc_time),
    .rtc_word       (rtc_word)
  );

endmodule

/* tb_core_top.sv */
/*
 * core_top testbench
 * table-driven checks of reset, reset pulse, stick deadzone,
 * colour correction, end-of-line slot word and rtc packing
 */
module tb_core_top;

  localparam int op_reset = 0;
  localparam int op_pulse = 1;
  localparam int op_dead  = 2;
  localparam int op_color = 3;
  localparam int op_slot  = 4;
  localparam int op_rtc   = 5;
  localparam int max_rows = 64;

  logic        clk_74a;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] cont1_joy;
  logic [31:0] rtc_date;
  logic [31:0] rtc_time;
  logic [23:0] rgb_in;
  logic        de_in;
  logic        vs_in;
  logic [7:0]  snap_index;
  logic        core_reset;
  logic [7:0]  stick_x;
  logic [7:0]  stick_y;
  logic [23:0] video_rgb;
  logic        video_de;
  logic [64:0] rtc_word;

  // stimulus table with one entry per test
  int          row_kind [max_rows];
  logic [31:0] row_s0 [max_rows];
  logic [31:0] row_s1 [max_rows];
  logic [31:0] row_s2 [max_rows];
  logic [64:0] row_exp [max_rows];
  int          n_rows;
  int          row_errors;
  int          total_errors;
  int          tests_failed;
  logic [31:0] cur_pct;
  logic [31:0] last_time;
  logic        rtc_toggle;

  core_top #(
    .reset_pulse_cycles(16)
  ) i_dut (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .cont1_joy      (cont1_joy),
    .rtc_date       (rtc_date),
    .rtc_time       (rtc_time),
    .rgb_in         (rgb_in),
    .de_in          (de_in),
    .vs_in          (vs_in),
    .snap_index     (snap_index),
    .core_reset     (core_reset),
    .stick_x        (stick_x),
    .stick_y        (stick_y),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .rtc_word       (rtc_word)
  );

  initial begin
    clk_74a = 1'b0;
    forever #50 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////
  // reference model

  function automatic int axis_distance(input int v);
    int low;
    low = v % 128;
    return (v >= 128) ? low : 128 - low;
  endfunction

  // {x, y} seen one cycle later
  function automatic int expect_stick(input int dz, input int x, input int y);
    if (axis_distance(x) + axis_distance(y) > dz) begin
      return x * 256 + y;
    end
    return 128 * 256 + 128;
  endfunction

  function automatic int corrected_channel(input int c, input int gain, input int pct);
    int cc;
    int v;
    cc = pct * 255 / 100;
    v  = (c * (255 - cc) + ((c * gain) / 256) * cc) / 256;
    return (v > 255) ? 255 : v;
  endfunction

  function automatic logic [23:0] corrected_pixel(input logic [23:0] p, input int pct);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = 8'(corrected_channel(int'(p[23:16]), int'(core_pkg::gain_r), pct));
    g = 8'(corrected_channel(int'(p[15:8]), int'(core_pkg::gain_g), pct));
    b = 8'(corrected_channel(int'(p[7:0]), int'(core_pkg::gain_b), pct));
    return {r, g, b};
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      op_reset: return "reset";
      op_pulse: return "reset pulse";
      op_dead:  return "deadzone";
      op_color: return "colour correction";
      op_slot:  return "slot word";
      default:  return "rtc";
    endcase
  endfunction

  ////////////////////////////////////////
  // table building

  task automatic add_row(input int kind, input logic [31:0] s0, input logic [31:0] s1,
                         input logic [31:0] s2, input logic [64:0] exp_val);
    row_kind[n_rows] = kind;
    row_s0[n_rows]   = s0;
    row_s1[n_rows]   = s1;
    row_s2[n_rows]   = s2;
    row_exp[n_rows]  = exp_val;
    n_rows++;
  endtask

  task automatic add_dead_row(input int dz, input int x, input int y);
    add_row(op_dead, dz, x, y, 65'(expect_stick(dz, x, y)));
  endtask

  task automatic add_color_row(input int pct, input logic [23:0] pix);
    add_row(op_color, pct, 32'(pix), 32'h0, 65'(corrected_pixel(pix, pct)));
  endtask

  task automatic add_slot_row(input logic [7:0] snap, input logic sq);
    core_pkg::video_word_u word;
    word = '0;
    word.slot.slot_interlace_odd = ~snap[0];
    word.slot.slot_square = sq;
    add_row(op_slot, 32'(snap), 32'(sq), $urandom(), 65'(word));
  endtask

  task automatic add_rtc_row(input logic [31:0] date, input logic [31:0] tm);
    if (tm != last_time) begin
      rtc_toggle = ~rtc_toggle;
      last_time  = tm;
    end
    add_row(op_rtc, date, tm, 32'h0, {rtc_toggle, 8'h00, 8'h01, date[23:0], tm[23:0]});
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    add_row(op_reset, 32'h0, 32'h0, 32'h0, 65'h0);
    add_row(op_pulse, 32'h0, 32'h0, 32'h0, 65'd16);
    // totals at and just above the deadzone
    add_dead_row(20, 138, 118);
    add_dead_row(19, 138, 118);
    add_dead_row(0, 128, 128);
    add_dead_row(0, 129, 128);
    add_dead_row(255, 0, 0);
    add_dead_row(255, 0, 128);
    repeat (4) begin
      rnd = $urandom();
      add_dead_row(int'(rnd[7:0]), int'(rnd[15:8]), int'(rnd[23:16]));
    end
    foreach (row_s2[k]) begin
      if (k < 3) begin
        add_color_row(k * 50, 24'hffffff);
        repeat (3) add_color_row(k * 50, 24'($urandom()));
      end
    end
    add_slot_row(8'h02, 1'b1);
    add_slot_row(8'h05, 1'b0);
    add_slot_row(8'($urandom()), 1'b1);
    add_rtc_row(32'h0024_0315, 32'h0012_3456);
    add_rtc_row(32'h0024_0315, 32'h0012_3456);
    add_rtc_row(32'h0099_1231, 32'h0023_5959);
  endtask

  ////////////////////////////////////////
  // checks and drivers

  task automatic check_value(input string name, input logic [64:0] got,
                             input logic [64:0] exp_val);
    assert (got === exp_val) else begin
      $display("mismatch %s got %0h expected %0h", name, got, exp_val);
      row_errors++;
    end
  endtask

  task automatic check_idle_outputs();
    check_value("video_de", 65'(video_de), 65'(0));
    check_value("stick_x", 65'(stick_x), 65'(128));
    check_value("stick_y", 65'(stick_y), 65'(128));
    check_value("rtc_word[64]", 65'(rtc_word[64]), 65'(0));
  endtask

  // one write strobe that returns on the following falling edge
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic run_row(input int i);
    int cycles;
    case (row_kind[i])
      op_reset: begin
        pll_core_locked = 1'b0;
        repeat (5) begin
          @(negedge clk_74a);
          check_value("core_reset", 65'(core_reset), 65'(1));
          check_idle_outputs();
        end
        pll_core_locked = 1'b1;
        @(negedge clk_74a);
        check_value("core_reset", 65'(core_reset), 65'(0));
        check_idle_outputs();
      end
      op_pulse: begin
        bridge_write(core_pkg::addr_reset_pulse, $urandom());
        cycles = 0;
        while (core_reset && cycles < 100) begin
          cycles++;
          @(negedge clk_74a);
        end
        assert (!core_reset) else begin
          $display("core_reset still high 100 cycles after the pulse write");
          row_errors++;
        end
        check_value("core_reset cycles", 65'(cycles), row_exp[i]);
      end
      op_dead: begin
        bridge_write(core_pkg::addr_deadzone, row_s0[i]);
        cont1_joy = {16'h0, row_s2[i][7:0], row_s1[i][7:0]};
        @(negedge clk_74a);
        check_value("stick_x", 65'(stick_x), 65'(row_exp[i][15:8]));
        check_value("stick_y", 65'(stick_y), 65'(row_exp[i][7:0]));
      end
      op_color: begin
        if (row_s0[i] != cur_pct) begin
          de_in = 1'b0;
          bridge_write(core_pkg::addr_color_corr, row_s0[i]);
          cur_pct = row_s0[i];
        end
        rgb_in = row_s1[i][23:0];
        de_in  = 1'b1;
        @(negedge clk_74a);
        check_value("video_de", 65'(video_de), 65'(1));
        check_value("video_rgb", 65'(video_rgb), row_exp[i]);
      end
      op_slot: begin
        de_in = 1'b0;
        bridge_write(core_pkg::addr_square_pixels, row_s1[i]);
        vs_in      = 1'b1;
        snap_index = row_s0[i][7:0];
        @(negedge clk_74a);
        // index moves on after vsync while the latched one stays
        vs_in      = 1'b0;
        snap_index = ~row_s0[i][7:0];
        rgb_in     = row_s2[i][23:0];
        de_in      = 1'b1;
        @(negedge clk_74a);
        de_in = 1'b0;
        @(negedge clk_74a);
        check_value("video_de", 65'(video_de), 65'(0));
        check_value("video_rgb", 65'(video_rgb), row_exp[i]);
      end
      default: begin
        rtc_date = row_s0[i];
        rtc_time = row_s1[i];
        @(negedge clk_74a);
        check_value("rtc_word", rtc_word, row_exp[i]);
      end
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    // both axes at neutral
    cont1_joy       = 32'h0000_8080;
    rtc_date        = '0;
    rtc_time        = '0;
    rgb_in          = '0;
    de_in           = 1'b0;
    vs_in           = 1'b0;
    snap_index      = '0;
    n_rows          = 0;
    total_errors    = 0;
    tests_failed    = 0;
    cur_pct         = 32'hffff_ffff;
    last_time       = '0;
    rtc_toggle      = 1'b0;
    void'($urandom(32'h31e2_0b58));
    build_table();
    for (int i = 0; i < n_rows; i++) begin
      row_errors = 0;
      run_row(i);
      if (row_errors == 0) begin
        $display("test %0d %s ok", i, kind_name(row_kind[i]));
      end else begin
        $display("test %0d %s failed with %0d errors", i, kind_name(row_kind[i]), row_errors);
        tests_failed++;
      end
      total_errors += row_errors;
    end
    $display("summary: %0d tests, %0d failed, %0d failing checks",
             n_rows, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
core_pkg.sv
core_settings_regs.sv
stick_deadzone.sv
color_correct.sv
rtc_packer.sv
core_top.sv
tb_core_top.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
verilator --binary --timing --assert --top-module tb_core_top -f build.f -o sim_core_top \
  && ./obj_dir/sim_core_top | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
